//--- hdl/box_sim_pkg.sv
// Shared types, colour constants and default raster and box parameters
package box_sim_pkg;

    // Signed screen coordinate or velocity in whole pixels
    typedef logic signed [10:0] coord_t;

    // State of one box, position is the top-left corner
    typedef struct packed {
        coord_t pos_x;
        coord_t pos_y;
        coord_t vel_x;
        coord_t vel_y;
    } box_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // Video word as it leaves the design
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic vde;
        rgb_t rgb;
    } video_t;

    // Raster position with the matching sync and active levels
    typedef struct packed {
        coord_t draw_x;
        coord_t draw_y;
        logic   hsync;
        logic   vsync;
        logic   vde;
    } raster_t;

    // -------------------------------------------------------------------------
    // Colours
    // -------------------------------------------------------------------------
    localparam rgb_t COLOR_BG   = '{red: 4'h1, green: 4'h1, blue: 4'h3};
    localparam rgb_t COLOR_BOX1 = '{red: 4'hF, green: 4'h8, blue: 4'h0};
    localparam rgb_t COLOR_BOX2 = '{red: 4'h0, green: 4'hC, blue: 4'hF};
    localparam rgb_t COLOR_HIT  = '{red: 4'hF, green: 4'hF, blue: 4'hF};

    // -------------------------------------------------------------------------
    // Default 640x480 timing and box size
    // -------------------------------------------------------------------------
    localparam int H_ACTIVE_DEF = 640;
    localparam int H_FRONT_DEF  = 16;
    localparam int H_SYNC_DEF   = 96;
    localparam int H_BACK_DEF   = 48;
    localparam int V_ACTIVE_DEF = 480;
    localparam int V_FRONT_DEF  = 10;
    localparam int V_SYNC_DEF   = 2;
    localparam int V_BACK_DEF   = 33;
    localparam int BOX_SIZE_DEF = 16;

endpackage

//--- hdl/vga_timing.sv
// Raster counters, registered sync and active levels, start-of-blanking pulse
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = box_sim_pkg::H_ACTIVE_DEF,
    parameter int H_FRONT  = box_sim_pkg::H_FRONT_DEF,
    parameter int H_SYNC   = box_sim_pkg::H_SYNC_DEF,
    parameter int H_BACK   = box_sim_pkg::H_BACK_DEF,
    parameter int V_ACTIVE = box_sim_pkg::V_ACTIVE_DEF,
    parameter int V_FRONT  = box_sim_pkg::V_FRONT_DEF,
    parameter int V_SYNC   = box_sim_pkg::V_SYNC_DEF,
    parameter int V_BACK   = box_sim_pkg::V_BACK_DEF
) (
    input  logic                 pixel_clk_i,
    input  logic                 arst_n_i,
    output box_sim_pkg::raster_t raster_o,
    output logic                 frame_tick_o
);
    import box_sim_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam coord_t H_LAST       = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST       = coord_t'(V_TOTAL - 1);
    localparam coord_t H_ACT        = coord_t'(H_ACTIVE);
    localparam coord_t V_ACT        = coord_t'(V_ACTIVE);
    localparam coord_t H_SYNC_START = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t H_SYNC_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t V_SYNC_START = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t V_SYNC_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam coord_t ZERO         = '0;

    coord_t h_cnt;
    coord_t v_cnt;

    // Pixel and line counters
    always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_cnt <= ZERO;
            v_cnt <= ZERO;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= ZERO;
            v_cnt <= (v_cnt == V_LAST) ? ZERO : v_cnt + 11'sd1;
        end else begin
            h_cnt <= h_cnt + 11'sd1;
        end
    end

    // Sync is active low, one register stage behind the counters
    always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            raster_o     <= '{draw_x: ZERO, draw_y: ZERO, hsync: 1'b1, vsync: 1'b1, vde: 1'b0};
            frame_tick_o <= 1'b0;
        end else begin
            raster_o.draw_x <= h_cnt;
            raster_o.draw_y <= v_cnt;
            raster_o.hsync  <= !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
            raster_o.vsync  <= !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
            raster_o.vde    <= (h_cnt < H_ACT) && (v_cnt < V_ACT);
            // First pixel of the first blanking line
            frame_tick_o    <= (h_cnt == ZERO) && (v_cnt == V_ACT);
        end
    end

endmodule

//--- hdl/box_physics.sv
// Two box state registers with per-frame motion, wall bounce and collision swap
`timescale 1ns/1ps

module box_physics #(
    parameter int                H_ACTIVE  = box_sim_pkg::H_ACTIVE_DEF,
    parameter int                V_ACTIVE  = box_sim_pkg::V_ACTIVE_DEF,
    parameter int                BOX_SIZE  = box_sim_pkg::BOX_SIZE_DEF,
    parameter box_sim_pkg::box_t BOX1_INIT = '0,
    parameter box_sim_pkg::box_t BOX2_INIT = '0
) (
    input  logic              pixel_clk_i,
    input  logic              arst_n_i,
    input  logic              run_i,
    input  logic              frame_tick_i,
    output box_sim_pkg::box_t box1_o,
    output box_sim_pkg::box_t box2_o,
    output logic              hit_o
);
    import box_sim_pkg::*;

    localparam coord_t SIZE  = coord_t'(BOX_SIZE);
    localparam coord_t X_MAX = coord_t'(H_ACTIVE - BOX_SIZE);
    localparam coord_t Y_MAX = coord_t'(V_ACTIVE - BOX_SIZE);
    localparam coord_t ZERO  = '0;

    box_t box1_q;
    box_t box2_q;
    box_t box1_sw;
    box_t box2_sw;
    box_t box1_d;
    box_t box2_d;
    logic overlap;
    logic hit_q;

    // -------------------------------------------------------------------------
    // Motion helpers
    // -------------------------------------------------------------------------

    // One axis: integrate, then clamp to [0, lim] and reverse on a wall hit
    function automatic void reflect(
        input  coord_t pos_in,
        input  coord_t vel_in,
        input  coord_t lim,
        output coord_t pos_out,
        output coord_t vel_out
    );
        coord_t sum;
        sum = pos_in + vel_in;
        if (sum < ZERO) begin
            pos_out = ZERO;
            vel_out = -vel_in;
        end else if (sum > lim) begin
            pos_out = lim;
            vel_out = -vel_in;
        end else begin
            pos_out = sum;
            vel_out = vel_in;
        end
    endfunction

    function automatic box_t step_box(input box_t b);
        box_t   r;
        coord_t px;
        coord_t py;
        coord_t vx;
        coord_t vy;
        reflect(b.pos_x, b.vel_x, X_MAX, px, vx);
        reflect(b.pos_y, b.vel_y, Y_MAX, py, vy);
        r = '{pos_x: px, pos_y: py, vel_x: vx, vel_y: vy};
        return r;
    endfunction

    // -------------------------------------------------------------------------
    // Next state
    // -------------------------------------------------------------------------
    always_comb begin
        // Axis-aligned overlap on both axes
        overlap = (box1_q.pos_x < box2_q.pos_x + SIZE) &&
                  (box2_q.pos_x < box1_q.pos_x + SIZE) &&
                  (box1_q.pos_y < box2_q.pos_y + SIZE) &&
                  (box2_q.pos_y < box1_q.pos_y + SIZE);

        box1_sw = box1_q;
        box2_sw = box2_q;
        // Equal masses, so an elastic hit just trades velocities
        if (overlap) begin
            box1_sw.vel_x = box2_q.vel_x;
            box1_sw.vel_y = box2_q.vel_y;
            box2_sw.vel_x = box1_q.vel_x;
            box2_sw.vel_y = box1_q.vel_y;
        end

        box1_d = step_box(box1_sw);
        box2_d = step_box(box2_sw);
    end

    // State update once per frame while running
    always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            box1_q <= BOX1_INIT;
            box2_q <= BOX2_INIT;
            hit_q  <= 1'b0;
        end else if (frame_tick_i && run_i) begin
            box1_q <= box1_d;
            box2_q <= box2_d;
            hit_q  <= overlap;
        end
    end

    assign box1_o = box1_q;
    assign box2_o = box2_q;
    assign hit_o  = hit_q;

endmodule

//--- hdl/pixel_mapper.sv
// Per-pixel box coverage, colour priority and registered video output
`timescale 1ns/1ps

module pixel_mapper #(
    parameter int BOX_SIZE = box_sim_pkg::BOX_SIZE_DEF
) (
    input  logic                 pixel_clk_i,
    input  logic                 arst_n_i,
    input  box_sim_pkg::raster_t raster_i,
    input  box_sim_pkg::box_t    box1_i,
    input  box_sim_pkg::box_t    box2_i,
    input  logic                 hit_i,
    output box_sim_pkg::video_t  video_o
);
    import box_sim_pkg::*;

    localparam coord_t SIZE = coord_t'(BOX_SIZE);

    logic   in_box1;
    logic   in_box2;
    rgb_t   pix_rgb;
    video_t video_q;

    // True when (x, y) lies in the square at the box position
    function automatic logic covers(input box_t b, input coord_t x, input coord_t y);
        return (x >= b.pos_x) && (x < b.pos_x + SIZE) &&
               (y >= b.pos_y) && (y < b.pos_y + SIZE);
    endfunction

    assign in_box1 = covers(box1_i, raster_i.draw_x, raster_i.draw_y);
    assign in_box2 = covers(box2_i, raster_i.draw_x, raster_i.draw_y);

    // Colour priority: blanking, hit, box 1, box 2, background
    always_comb begin
        if (!raster_i.vde) begin
            pix_rgb = '0;
        end else if ((in_box1 || in_box2) && hit_i) begin
            pix_rgb = COLOR_HIT;
        end else if (in_box1) begin
            pix_rgb = COLOR_BOX1;
        end else if (in_box2) begin
            pix_rgb = COLOR_BOX2;
        end else begin
            pix_rgb = COLOR_BG;
        end
    end

    // Colour and syncs share one stage so they stay aligned
    always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            video_q <= '{hsync: 1'b1, vsync: 1'b1, vde: 1'b0, rgb: COLOR_BG};
        end else begin
            video_q.hsync <= raster_i.hsync;
            video_q.vsync <= raster_i.vsync;
            video_q.vde   <= raster_i.vde;
            video_q.rgb   <= pix_rgb;
        end
    end

    assign video_o = video_q;

endmodule

//--- hdl/box_sim_top.sv
// Top level joining raster timing, box physics and pixel colour mapping
`timescale 1ns/1ps

module box_sim_top #(
    parameter int                H_ACTIVE  = box_sim_pkg::H_ACTIVE_DEF,
    parameter int                H_FRONT   = box_sim_pkg::H_FRONT_DEF,
    parameter int                H_SYNC    = box_sim_pkg::H_SYNC_DEF,
    parameter int                H_BACK    = box_sim_pkg::H_BACK_DEF,
    parameter int                V_ACTIVE  = box_sim_pkg::V_ACTIVE_DEF,
    parameter int                V_FRONT   = box_sim_pkg::V_FRONT_DEF,
    parameter int                V_SYNC    = box_sim_pkg::V_SYNC_DEF,
    parameter int                V_BACK    = box_sim_pkg::V_BACK_DEF,
    parameter int                BOX_SIZE  = box_sim_pkg::BOX_SIZE_DEF,
    parameter box_sim_pkg::box_t BOX1_INIT = '{pos_x: 11'sd100, pos_y: 11'sd80,
                                               vel_x: 11'sd3, vel_y: 11'sd2},
    parameter box_sim_pkg::box_t BOX2_INIT = '{pos_x: 11'sd400, pos_y: 11'sd200,
                                               vel_x: -11'sd2, vel_y: 11'sd1}
) (
    input  logic                pixel_clk_i,
    input  logic                arst_n_i,
    input  logic                run_i,
    output box_sim_pkg::video_t video_o
);
    import box_sim_pkg::*;

    raster_t raster;
    logic    frame_tick;
    box_t    box1;
    box_t    box2;
    logic    hit;

    // -------------------------------------------------------------------------
    // Raster timing
    // -------------------------------------------------------------------------
    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_timing (
        .pixel_clk_i  (pixel_clk_i),
        .arst_n_i     (arst_n_i),
        .raster_o     (raster),
        .frame_tick_o (frame_tick)
    );

    // Physics steps during vertical blanking
    box_physics #(
        .H_ACTIVE  (H_ACTIVE),
        .V_ACTIVE  (V_ACTIVE),
        .BOX_SIZE  (BOX_SIZE),
        .BOX1_INIT (BOX1_INIT),
        .BOX2_INIT (BOX2_INIT)
    ) u_physics (
        .pixel_clk_i  (pixel_clk_i),
        .arst_n_i     (arst_n_i),
        .run_i        (run_i),
        .frame_tick_i (frame_tick),
        .box1_o       (box1),
        .box2_o       (box2),
        .hit_o        (hit)
    );

    // -------------------------------------------------------------------------
    // Colour output
    // -------------------------------------------------------------------------
    pixel_mapper #(
        .BOX_SIZE (BOX_SIZE)
    ) u_mapper (
        .pixel_clk_i (pixel_clk_i),
        .arst_n_i    (arst_n_i),
        .raster_i    (raster),
        .box1_i      (box1),
        .box2_i      (box2),
        .hit_i       (hit),
        .video_o     (video_o)
    );

endmodule

//--- bench/box_sim_model.svh
// Reference model of box motion, overlap swap and expected video word per position
`ifndef BOX_SIM_MODEL_SVH
`define BOX_SIM_MODEL_SVH

// Integrate one axis, walls at 0 and lim reflect the velocity
function automatic void bounce_axis(inout int pos, inout int vel, input int lim);
    pos = pos + vel;
    if (pos < 0) begin
        pos = 0;
        vel = -vel;
    end else if (pos > lim) begin
        pos = lim;
        vel = -vel;
    end
endfunction

function automatic box_t move_box(input box_t b);
    box_t r;
    int   px;
    int   py;
    int   vx;
    int   vy;
    px = int'(b.pos_x);
    py = int'(b.pos_y);
    vx = int'(b.vel_x);
    vy = int'(b.vel_y);
    bounce_axis(px, vx, H_ACT - BOX_SZ);
    bounce_axis(py, vy, V_ACT - BOX_SZ);
    r.pos_x = coord_t'(px);
    r.pos_y = coord_t'(py);
    r.vel_x = coord_t'(vx);
    r.vel_y = coord_t'(vy);
    return r;
endfunction

// One physics update at the start of vertical blanking
task automatic step_frame(inout box_t b1, inout box_t b2, inout logic hit);
    box_t n1;
    box_t n2;
    int   dx;
    int   dy;
    n1 = b1;
    n2 = b2;
    dx = int'(b1.pos_x) - int'(b2.pos_x);
    dy = int'(b1.pos_y) - int'(b2.pos_y);
    // Equal squares overlap when both corner distances stay below the edge
    hit = (dx < BOX_SZ) && (-dx < BOX_SZ) && (dy < BOX_SZ) && (-dy < BOX_SZ);
    if (hit) begin
        n1.vel_x = b2.vel_x;
        n1.vel_y = b2.vel_y;
        n2.vel_x = b1.vel_x;
        n2.vel_y = b1.vel_y;
    end
    b1 = move_box(n1);
    b2 = move_box(n2);
endtask

function automatic logic covers_pixel(input box_t b, input int h, input int v);
    int px;
    int py;
    px = int'(b.pos_x);
    py = int'(b.pos_y);
    return (h >= px) && (h < px + BOX_SZ) && (v >= py) && (v < py + BOX_SZ);
endfunction

// Video word for raster position q counted from reset release
function automatic video_t predict_video(input int q, input box_t b1, input box_t b2,
                                         input logic hit);
    video_t vid;
    int     h;
    int     v;
    logic   c1;
    logic   c2;
    if (q < 0) begin
        vid = '{hsync: 1'b1, vsync: 1'b1, vde: 1'b0, rgb: 12'h000};
        return vid;
    end
    h = q % H_TOT;
    v = (q / H_TOT) % V_TOT;
    c1 = covers_pixel(b1, h, v);
    c2 = covers_pixel(b2, h, v);
    vid.hsync = !((h >= H_ACT + H_FP) && (h < H_ACT + H_FP + H_SW));
    vid.vsync = !((v >= V_ACT + V_FP) && (v < V_ACT + V_FP + V_SW));
    vid.vde   = (h < H_ACT) && (v < V_ACT);
    if (!vid.vde) begin
        vid.rgb = 12'h000;
    end else if ((c1 || c2) && hit) begin
        vid.rgb = COLOR_HIT;
    end else if (c1) begin
        vid.rgb = COLOR_BOX1;
    end else if (c2) begin
        vid.rgb = COLOR_BOX2;
    end else begin
        vid.rgb = COLOR_BG;
    end
    return vid;
endfunction

`endif

//--- bench/box_sim_tb.sv
// Testbench for the box simulation core: clock, reset, frame table, checks, timeout
`timescale 1ns/1ps

module box_sim_tb;
    import box_sim_pkg::*;

    localparam int H_ACT        = 32;
    localparam int H_FP         = 2;
    localparam int H_SW         = 4;
    localparam int H_BP         = 2;
    localparam int V_ACT        = 24;
    localparam int V_FP         = 2;
    localparam int V_SW         = 4;
    localparam int V_BP         = 2;
    localparam int BOX_SZ       = 6;
    localparam int H_TOT        = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_TOT        = V_ACT + V_FP + V_SW + V_BP;
    localparam int FRAME_CYCLES = H_TOT * V_TOT;
    localparam int RESET_CYCLES = 10;
    localparam int ROWS         = 20;
    localparam int CYCLE_LIMIT  = ROWS * FRAME_CYCLES + RESET_CYCLES + 100;

    localparam box_t BOX1_START = '{pos_x: 11'sd2, pos_y: 11'sd3,
                                    vel_x: 11'sd3, vel_y: 11'sd1};
    localparam box_t BOX2_START = '{pos_x: 11'sd22, pos_y: 11'sd4,
                                    vel_x: -11'sd2, vel_y: 11'sd1};
    localparam video_t IDLE_VIDEO = '{hsync: 1'b1, vsync: 1'b1, vde: 1'b0, rgb: COLOR_BG};

    // One frame: run level, both top-left corners, colour seen at each corner
    typedef struct packed {
        logic   run;
        coord_t x1;
        coord_t y1;
        coord_t x2;
        coord_t y2;
        rgb_t   col1;
        rgb_t   col2;
    } row_t;

    // -------------------------------------------------------------------------
    // Frame table
    // -------------------------------------------------------------------------
    localparam row_t FRAME_TABLE [ROWS] = '{
        '{1'b1, 11'sd2,  11'sd3,  11'sd22, 11'sd4,  COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd5,  11'sd4,  11'sd20, 11'sd5,  COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd8,  11'sd5,  11'sd18, 11'sd6,  COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd11, 11'sd6,  11'sd16, 11'sd7,  COLOR_BOX1, COLOR_BOX1},
        '{1'b0, 11'sd9,  11'sd7,  11'sd19, 11'sd8,  COLOR_HIT,  COLOR_HIT},
        '{1'b0, 11'sd9,  11'sd7,  11'sd19, 11'sd8,  COLOR_HIT,  COLOR_HIT},
        '{1'b0, 11'sd9,  11'sd7,  11'sd19, 11'sd8,  COLOR_HIT,  COLOR_HIT},
        '{1'b1, 11'sd9,  11'sd7,  11'sd19, 11'sd8,  COLOR_HIT,  COLOR_HIT},
        '{1'b1, 11'sd7,  11'sd8,  11'sd22, 11'sd9,  COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd5,  11'sd9,  11'sd25, 11'sd10, COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd3,  11'sd10, 11'sd26, 11'sd11, COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd1,  11'sd11, 11'sd23, 11'sd12, COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd0,  11'sd12, 11'sd20, 11'sd13, COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd2,  11'sd13, 11'sd17, 11'sd14, COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd4,  11'sd14, 11'sd14, 11'sd15, COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd6,  11'sd15, 11'sd11, 11'sd16, COLOR_BOX1, COLOR_BOX1},
        '{1'b1, 11'sd3,  11'sd16, 11'sd13, 11'sd17, COLOR_HIT,  COLOR_HIT},
        '{1'b1, 11'sd0,  11'sd17, 11'sd15, 11'sd18, COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd0,  11'sd18, 11'sd17, 11'sd18, COLOR_BOX1, COLOR_BOX2},
        '{1'b1, 11'sd3,  11'sd18, 11'sd19, 11'sd17, COLOR_BOX1, COLOR_BOX2}
    };

    logic   pixel_clk;
    logic   arst_n;
    logic   run;
    video_t video;
    int     video_errors = 0;
    int     rgb_errors = 0;
    int     cycles = 0;

    `include "box_sim_model.svh"

    box_sim_top #(
        .H_ACTIVE  (H_ACT),
        .H_FRONT   (H_FP),
        .H_SYNC    (H_SW),
        .H_BACK    (H_BP),
        .V_ACTIVE  (V_ACT),
        .V_FRONT   (V_FP),
        .V_SYNC    (V_SW),
        .V_BACK    (V_BP),
        .BOX_SIZE  (BOX_SZ),
        .BOX1_INIT (BOX1_START),
        .BOX2_INIT (BOX2_START)
    ) uut (
        .pixel_clk_i (pixel_clk),
        .arst_n_i    (arst_n),
        .run_i       (run),
        .video_o     (video)
    );

    initial begin
        pixel_clk = 1'b0;
        forever #20 pixel_clk = ~pixel_clk;
    end

    // Run limit from the table length
    always @(posedge pixel_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // -------------------------------------------------------------------------
    // Compare tasks
    // -------------------------------------------------------------------------
    task automatic check_video(input video_t got, input video_t exp, input string where);
        if (got !== exp) begin
            video_errors++;
            $display("MISMATCH video_o at %s: got %h, expected %h", where, got, exp);
        end
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string name);
        if (got !== exp) begin
            rgb_errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    initial begin : run_frames
        box_t b1;
        box_t b2;
        logic hit;
        row_t row;
        int   q;
        int   h;
        int   v;
        b1     = BOX1_START;
        b2     = BOX2_START;
        hit    = 1'b0;
        arst_n = 1'b0;
        run    = 1'b0;
        repeat (RESET_CYCLES) @(posedge pixel_clk);
        arst_n <= 1'b1;
        @(negedge pixel_clk);
        check_video(video, IDLE_VIDEO, "reset");
        for (int r = 0; r < ROWS; r++) begin
            row = FRAME_TABLE[r];
            for (int c = 0; c < FRAME_CYCLES; c++) begin
                @(posedge pixel_clk);
                if (c == 0) begin
                    run <= row.run;
                end
                @(negedge pixel_clk);
                // Output trails the raster counters by two cycles
                q = r * FRAME_CYCLES + c - 1;
                h = q % H_TOT;
                v = (q / H_TOT) % V_TOT;
                check_video(video, predict_video(q, b1, b2, hit), $sformatf("position %0d", q));
                if (h == int'(row.x1) && v == int'(row.y1)) begin
                    check_rgb(video.rgb, row.col1, "video_o.rgb at box 1 corner");
                end
                if (h == int'(row.x2) && v == int'(row.y2)) begin
                    check_rgb(video.rgb, row.col2, "video_o.rgb at box 2 corner");
                end
                // Physics steps once the first blanking line starts
                if (q % FRAME_CYCLES == V_ACT * H_TOT && row.run) begin
                    step_frame(b1, b2, hit);
                end
            end
        end
        $display("Errors: %0d video, %0d corner colour", video_errors, rgb_errors);
        if (video_errors == 0 && rgb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- box_sim.f
+incdir+bench
hdl/box_sim_pkg.sv
hdl/vga_timing.sv
hdl/box_physics.sv
hdl/pixel_mapper.sv
hdl/box_sim_top.sv
bench/box_sim_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --top-module box_sim_tb -Mdir obj_dir -f box_sim.f
	./obj_dir/Vbox_sim_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
